//--- design/core_front_top.sv
// core front top, decode/register read, forwarding and execute/writeback stages
`timescale 1ns/1ns

`include "core_params.svh"

module core_front_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [`XLEN-1:0]   instr_i,
    input  logic               instr_valid_i,
    input  logic [`XLEN-1:0]   pc_i,
    output logic               wb_valid_o,
    output logic [`REG_AW-1:0] wb_rd_o,
    output logic [`XLEN-1:0]   wb_value_o,
    output logic [`XLEN-1:0]   wb_pc_o,
    output logic               illegal_o
);
    import pipe_pkg::*;

    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    fwd_sel_e           fwd1_sel;
    fwd_sel_e           fwd2_sel;
    logic [`XLEN-1:0]   exe_result;
    logic               dec_illegal; // illegal flag leaving decode

    dec_exe_if de_bus ();

    decode_regread u_decode (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .fwd1_sel_i    (fwd1_sel),
        .fwd2_sel_i    (fwd2_sel),
        .exe_fwd_i     (exe_result),
        .wb_fwd_i      (wb_value_o),
        .wr_addr_i     (wb_rd_o),
        .wr_data_i     (wb_value_o),
        .wr_en_i       (wb_valid_o),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .illegal_o     (dec_illegal),
        .de            (de_bus.dec)
    );

    forward_ctrl u_forward (
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .exe_valid_i (de_bus.valid),
        .exe_rd_i    (de_bus.rd),
        .wb_valid_i  (wb_valid_o),
        .wb_rd_i     (wb_rd_o),
        .fwd1_sel_o  (fwd1_sel),
        .fwd2_sel_o  (fwd2_sel)
    );

    execute_alu u_execute (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .illegal_i    (dec_illegal),
        .de           (de_bus.exe),
        .exe_result_o (exe_result),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_value_o   (wb_value_o),
        .wb_pc_o      (wb_pc_o),
        .illegal_o    (illegal_o)
    );

endmodule

//--- design/dec_exe_if.sv
// decode to execute bundle carrying one decoded instruction per cycle
`timescale 1ns/1ns

`include "core_params.svh"

interface dec_exe_if;
    import isa_pkg::*;

    logic              valid; // legal instruction in this slot
    uop_e              uop;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]  op1;   // already forwarded or replaced by pc/zero
    logic [`XLEN-1:0]  op2;   // already forwarded or replaced by the immediate
    logic [`XLEN-1:0]  pc;

    modport dec (output valid, uop, rd, op1, op2, pc);
    modport exe (input valid, uop, rd, op1, op2, pc);

endinterface

//--- design/decode_regread.sv
// decode and register read stage, builds the micro-op and forwarded operands
`timescale 1ns/1ns

`include "core_params.svh"

module decode_regread (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [`XLEN-1:0]   instr_i,
    input  logic               instr_valid_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  pipe_pkg::fwd_sel_e fwd1_sel_i,
    input  pipe_pkg::fwd_sel_e fwd2_sel_i,
    input  logic [`XLEN-1:0]   exe_fwd_i,
    input  logic [`XLEN-1:0]   wb_fwd_i,
    input  logic [`REG_AW-1:0] wr_addr_i,
    input  logic [`XLEN-1:0]   wr_data_i,
    input  logic               wr_en_i,
    output logic [`REG_AW-1:0] rs1_o,
    output logic [`REG_AW-1:0] rs2_o,
    output logic               illegal_o,
    dec_exe_if.dec             de
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic             f7_b5;
    logic             f7_rest_zero; // funct7 bits other than bit 5
    uop_e             uop;
    imm_fmt_e         imm_fmt;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;

    assign opcode       = opcode_e'(instr_i[6:2]);
    assign funct3       = instr_i[14:12];
    assign f7_b5        = instr_i[30];
    assign f7_rest_zero = (instr_i[31] == 1'b0) && (instr_i[29:25] == '0);
    assign rs1_o        = instr_i[19:15];
    assign rs2_o        = instr_i[24:20];

    always_comb begin
        uop     = UOP_ILLEGAL;
        imm_fmt = IMM_NONE;
        if ((instr_i[1:0] == 2'b11) && f7_rest_zero) begin // rv32 word, no M or custom funct7
            case (opcode)
                OP: begin
                    case (funct3)
                        3'b000:  uop = f7_b5 ? UOP_SUB : UOP_ADD;
                        3'b001:  uop = f7_b5 ? UOP_ILLEGAL : UOP_SLL;
                        3'b010:  uop = f7_b5 ? UOP_ILLEGAL : UOP_SLT;
                        3'b011:  uop = f7_b5 ? UOP_ILLEGAL : UOP_SLTU;
                        3'b100:  uop = f7_b5 ? UOP_ILLEGAL : UOP_XOR;
                        3'b101:  uop = f7_b5 ? UOP_SRA : UOP_SRL;
                        3'b110:  uop = f7_b5 ? UOP_ILLEGAL : UOP_OR;
                        default: uop = f7_b5 ? UOP_ILLEGAL : UOP_AND;
                    endcase
                end
                OP_IMM: begin
                    imm_fmt = IMM_I;
                    case (funct3)
                        3'b001:  uop = f7_b5 ? UOP_ILLEGAL : UOP_SLL;
                        3'b101:  uop = f7_b5 ? UOP_SRA : UOP_SRL;
                        default: uop = UOP_ILLEGAL; // non-shift ops decoded below
                    endcase
                end
                default: uop = UOP_ILLEGAL;
            endcase
        end

        // non-shift I-type immediates may use any upper bits
        if ((opcode == OP_IMM) && (instr_i[1:0] == 2'b11) && (funct3[1:0] != 2'b01)) begin
            imm_fmt = IMM_I;
            case (funct3)
                3'b000:  uop = UOP_ADD;
                3'b010:  uop = UOP_SLT;
                3'b011:  uop = UOP_SLTU;
                3'b100:  uop = UOP_XOR;
                3'b110:  uop = UOP_OR;
                default: uop = UOP_AND;
            endcase
        end

        // lui and auipc carry immediate bits in the funct7 field too
        if (((opcode == LUI) || (opcode == AUIPC)) && (instr_i[1:0] == 2'b11)) begin
            uop     = UOP_ADD;
            imm_fmt = IMM_U;
        end

        if (!instr_valid_i) begin
            uop = UOP_ILLEGAL; // empty slot
        end
    end

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                if (funct3[1:0] == 2'b01) begin
                    imm = {{(`XLEN-5){1'b0}}, instr_i[24:20]}; // shamt only
                end else begin
                    imm = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
                end
            end
            IMM_U:   imm = {instr_i[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd1_addr_i (rs1_o),
        .rd2_addr_i (rs2_o),
        .wr_addr_i  (wr_addr_i),
        .wr_data_i  (wr_data_i),
        .wr_en_i    (wr_en_i),
        .rd1_data_o (rs1_data),
        .rd2_data_o (rs2_data)
    );

    function automatic logic [`XLEN-1:0] fwd_pick(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] rf_val,
        input logic [`XLEN-1:0] exe_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            FWD_EXE: return exe_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    // selects apply only to operands read from registers
    always_comb begin
        case (opcode)
            AUIPC:   op1 = pc_i;
            LUI:     op1 = '0;
            default: op1 = fwd_pick(fwd1_sel_i, rs1_data, exe_fwd_i, wb_fwd_i);
        endcase
        if (imm_fmt != IMM_NONE) begin
            op2 = imm;
        end else begin
            op2 = fwd_pick(fwd2_sel_i, rs2_data, exe_fwd_i, wb_fwd_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            de.valid  <= 1'b0;
            de.uop    <= UOP_ILLEGAL;
            de.rd     <= '0;
            de.op1    <= '0;
            de.op2    <= '0;
            de.pc     <= '0;
            illegal_o <= 1'b0;
        end else begin
            de.valid  <= (uop != UOP_ILLEGAL);
            de.uop    <= uop;
            de.rd     <= instr_i[11:7];
            de.op1    <= op1;
            de.op2    <= op2;
            de.pc     <= pc_i;
            illegal_o <= instr_valid_i && (uop == UOP_ILLEGAL); // undecodable word
        end
    end

endmodule

//--- design/execute_alu.sv
// execute stage ALU and writeback register feeding the register file write port
`timescale 1ns/1ns

`include "core_params.svh"

module execute_alu (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               illegal_i,
    dec_exe_if.exe             de,
    output logic [`XLEN-1:0]   exe_result_o,
    output logic               wb_valid_o,
    output logic [`REG_AW-1:0] wb_rd_o,
    output logic [`XLEN-1:0]   wb_value_o,
    output logic [`XLEN-1:0]   wb_pc_o,
    output logic               illegal_o
);
    import isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = de.op2[4:0]; // rv32 shifts use 5 bits

    always_comb begin
        case (de.uop)
            UOP_ADD:  exe_result_o = de.op1 + de.op2;
            UOP_SUB:  exe_result_o = de.op1 - de.op2;
            UOP_AND:  exe_result_o = de.op1 & de.op2;
            UOP_OR:   exe_result_o = de.op1 | de.op2;
            UOP_XOR:  exe_result_o = de.op1 ^ de.op2;
            UOP_SLL:  exe_result_o = de.op1 << shamt;
            UOP_SRL:  exe_result_o = de.op1 >> shamt;
            UOP_SRA:  exe_result_o = $unsigned($signed(de.op1) >>> shamt); // sign fill
            UOP_SLT: begin
                exe_result_o = {{(`XLEN-1){1'b0}}, ($signed(de.op1) < $signed(de.op2))};
            end
            UOP_SLTU: exe_result_o = {{(`XLEN-1){1'b0}}, (de.op1 < de.op2)};
            default:  exe_result_o = '0; // bubble
        endcase
    end

    // wb outputs double as the register file write port
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_rd_o    <= '0;
            wb_value_o <= '0;
            wb_pc_o    <= '0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= de.valid;
            wb_rd_o    <= de.rd;
            wb_value_o <= exe_result_o;
            wb_pc_o    <= de.pc;
            illegal_o  <= illegal_i; // follows its slot
        end
    end

    // an illegal slot must never reach the register file
    a_illegal_no_write : assert property (@(posedge clk_i) disable iff (rst_i)
        illegal_i |=> !wb_valid_o)
        else $error("illegal slot reached writeback as valid");

endmodule

//--- design/forward_ctrl.sv
// operand forwarding control, matches decode sources against execute and writeback
`timescale 1ns/1ns

`include "core_params.svh"

module forward_ctrl (
    input  logic               [`REG_AW-1:0] rs1_i,
    input  logic               [`REG_AW-1:0] rs2_i,
    input  logic                             exe_valid_i,
    input  logic               [`REG_AW-1:0] exe_rd_i,
    input  logic                             wb_valid_i,
    input  logic               [`REG_AW-1:0] wb_rd_i,
    output pipe_pkg::fwd_sel_e               fwd1_sel_o,
    output pipe_pkg::fwd_sel_e               fwd2_sel_o
);
    import pipe_pkg::*;

    logic exe_live; // execute writes a real register
    logic wb_live;

    assign exe_live = exe_valid_i && (exe_rd_i != '0);
    assign wb_live  = wb_valid_i && (wb_rd_i != '0);

    function automatic fwd_sel_e pick_src(
        input logic [`REG_AW-1:0] rs,
        input logic               exe_hit_ok,
        input logic [`REG_AW-1:0] exe_rd,
        input logic               wb_hit_ok,
        input logic [`REG_AW-1:0] wb_rd
    );
        if (exe_hit_ok && (rs == exe_rd)) begin
            return FWD_EXE; // youngest producer first
        end else if (wb_hit_ok && (rs == wb_rd)) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign fwd1_sel_o = pick_src(rs1_i, exe_live, exe_rd_i, wb_live, wb_rd_i);
    assign fwd2_sel_o = pick_src(rs2_i, exe_live, exe_rd_i, wb_live, wb_rd_i);

endmodule

//--- design/isa_pkg.sv
// instruction set types for the RV32I integer ALU subset
package isa_pkg;

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OP     = 5'b01100, // register-register ALU
        OP_IMM = 5'b00100, // register-immediate ALU
        LUI    = 5'b01101,
        AUIPC  = 5'b00101
    } opcode_e;

    // micro-ops seen by the execute stage
    // illegal is zero so a cleared pipeline register is a bubble
    typedef enum logic [4:0] {
        UOP_ILLEGAL = 5'd0,
        UOP_ADD     = 5'd1, // also lui and auipc
        UOP_SUB     = 5'd2,
        UOP_AND     = 5'd3,
        UOP_OR      = 5'd4,
        UOP_XOR     = 5'd5,
        UOP_SLL     = 5'd6,
        UOP_SRL     = 5'd7,
        UOP_SRA     = 5'd8,
        UOP_SLT     = 5'd9,
        UOP_SLTU    = 5'd10
    } uop_e;

    // immediate layout of the instruction
    typedef enum logic [1:0] {
        IMM_NONE = 2'd0, // R-type, op2 from rs2
        IMM_I    = 2'd1,
        IMM_U    = 2'd2
    } imm_fmt_e;

endpackage

//--- design/pipe_pkg.sv
// pipeline control types for operand forwarding
package pipe_pkg;

    // operand source picked in decode
    // execute is the youngest result and wins over writeback
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0, // register file read
        FWD_EXE = 2'd1, // alu output of the instruction in execute
        FWD_WB  = 2'd2  // writeback register
    } fwd_sel_e;

endpackage

//--- design/reg_file.sv
// integer register file, two asynchronous reads, one clocked write, x0 tied to zero
`timescale 1ns/1ns

`include "core_params.svh"

module reg_file (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [`REG_AW-1:0] rd1_addr_i,
    input  logic [`REG_AW-1:0] rd2_addr_i,
    input  logic [`REG_AW-1:0] wr_addr_i,
    input  logic [`XLEN-1:0]   wr_data_i,
    input  logic               wr_en_i,
    output logic [`XLEN-1:0]   rd1_data_o,
    output logic [`XLEN-1:0]   rd2_data_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i; // x0 writes dropped
        end
    end

    // no write-through, same cycle hazards go through forwarding
    // x0 reads come from regs[0], cleared by reset and never written
    assign rd1_data_o = regs[rd1_addr_i];
    assign rd2_data_o = regs[rd2_addr_i];

    // x0 stays zero on both ports whatever was written before
    a_x0_zero : assert property (@(posedge clk_i) disable iff (rst_i)
        ((rd1_addr_i == '0) |-> (rd1_data_o == '0)) and
        ((rd2_addr_i == '0) |-> (rd2_data_o == '0)))
        else $error("x0 read back nonzero");

endmodule

//--- include/core_params.svh
// core parameters shared by the decode, execute and register file blocks
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path and pc width
`define XLEN 32

// register address width, rs1/rs2/rd fields
`define REG_AW 5

// architectural integer registers, x0 included
`define NUM_REGS 32

`endif

//--- run.sh
#!/bin/sh
# build and run the core front testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_core_front -f src.f -o tb_core_front
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core_front > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
exit 1

//--- src.f
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/dec_exe_if.sv
design/reg_file.sv
design/forward_ctrl.sv
design/decode_regread.sv
design/execute_alu.sv
design/core_front_top.sv
verification/tb_checker.sv
verification/tb_core_front.sv

//--- verification/alu_input.txt
# valid instr pc | expected wb_valid rd value illegal, all fields hex
# x1=5 and x2=-3 feed the register ops, x13 is the lui result
1 00500093 00000100 1 01 00000005 0
1 ffd00113 00000104 1 02 fffffffd 0
1 002081b3 00000108 1 03 00000002 0
1 40118233 0000010c 1 04 fffffffd 0
1 401252b3 00000110 1 05 ffffffff 0
1 00125333 00000114 1 06 07ffffff 0
1 002093b3 00000118 1 07 a0000000 0
1 00112433 0000011c 1 08 00000001 0
1 001134b3 00000120 1 09 00000000 0
1 0020c533 00000124 1 0a fffffff8 0
1 0020e5b3 00000128 1 0b fffffffd 0
1 0020f633 0000012c 1 0c 00000005 0
1 abcde6b7 00000130 1 0d abcde000 0
1 00001717 00000134 1 0e 00001134 0
1 4046d793 00000138 1 0f fabcde00 0
1 00309813 0000013c 1 10 00000028 0
1 01f6d893 00000140 1 11 00000001 0
1 ffe12913 00000144 1 12 00000001 0
1 fff0b993 00000148 1 13 00000001 0
1 fff0ca13 0000014c 1 14 fffffffa 0
1 7f00ea93 00000150 1 15 000007f5 0
1 0f017b13 00000154 1 16 000000f0 0
1 00708013 00000158 1 00 0000000c 0
1 00000bb3 0000015c 1 17 00000000 0
0 00000000 00000160 0 00 00000000 0
1 021080b3 00000164 0 00 00000000 1
1 00008c13 00000168 1 18 00000005 0

//--- verification/tb_checker.sv
// writeback checker, compares DUT writeback outputs with the expected slot queue
`timescale 1ns/1ns

module tb_checker (
    input logic        clk_i,
    input logic        rst_i,
    input logic        wb_valid_i,
    input logic [4:0]  wb_rd_i,
    input logic [31:0] wb_value_i,
    input logic [31:0] wb_pc_i,
    input logic        illegal_i
);
    int          error_count = 0;
    int          slot_count = 0;
    logic [70:0] entry; // pc, valid, rd, value, illegal

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s got %h expected %h in slot %0d", name, got, expected,
                     slot_count);
            error_count++;
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (tb_core_front.exp_q.size() >= 3) begin
                entry = tb_core_front.exp_q.pop_front(); // slot driven two edges back
                compare_field("wb_valid_o", 32'(wb_valid_i), 32'(entry[38]));
                compare_field("illegal_o", 32'(illegal_i), 32'(entry[0]));
                if (entry[38]) begin
                    compare_field("wb_rd_o", 32'(wb_rd_i), 32'(entry[37:33]));
                    compare_field("wb_value_o", wb_value_i, entry[32:1]);
                    compare_field("wb_pc_o", wb_pc_i, entry[70:39]);
                end
                slot_count++;
            end else begin
                // pipeline still filling after reset
                compare_field("wb_valid_o", 32'(wb_valid_i), 32'd0);
                compare_field("illegal_o", 32'(illegal_i), 32'd0);
            end
        end
    end

    task automatic print_summary();
        $display("checker: %0d slots compared, %0d errors", slot_count, error_count);
    endtask

endmodule

//--- verification/tb_core_front.sv
// testbench for the core front, drives instructions from a data file
`timescale 1ns/1ns

module tb_core_front;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 3; // push the last slots through writeback
    localparam int MAX_LINES    = 64;

    logic        clk_i;
    logic        rst_i;
    logic [31:0] instr_i;
    logic        instr_valid_i;
    logic [31:0] pc_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_value_o;
    logic [31:0] wb_pc_o;
    logic        illegal_o;

    logic [70:0] exp_q[$]; // read by the checker
    logic        stim_valid[MAX_LINES];
    logic [31:0] stim_instr[MAX_LINES];
    logic [31:0] stim_pc[MAX_LINES];
    logic [70:0] stim_exp[MAX_LINES];
    int          n_lines = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    core_front_top DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_value_o    (wb_value_o),
        .wb_pc_o       (wb_pc_o),
        .illegal_o     (illegal_o)
    );

    tb_checker u_checker (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_value_i (wb_value_o),
        .wb_pc_i    (wb_pc_o),
        .illegal_i  (illegal_o)
    );

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_valid, f_instr, f_pc, f_exp_valid, f_rd, f_value, f_illegal;
        fd = $fopen("verification/alu_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file verification/alu_input.txt");
        end else begin
            while ($fgets(line, fd) != 0 && n_lines < MAX_LINES) begin
                if (line.len() > 1 && line.getc(0) != "#") begin // skip comments
                    n = $sscanf(line, "%h %h %h %h %h %h %h", f_valid, f_instr, f_pc,
                                f_exp_valid, f_rd, f_value, f_illegal);
                    if (n == 7) begin
                        stim_valid[n_lines] = f_valid[0];
                        stim_instr[n_lines] = f_instr;
                        stim_pc[n_lines]    = f_pc;
                        stim_exp[n_lines]   = {f_pc, f_exp_valid[0], f_rd[4:0], f_value,
                                               f_illegal[0]};
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one slot per cycle, no back-pressure
    task automatic drive_slot(input logic valid, input logic [31:0] instr,
                              input logic [31:0] pc, input logic [70:0] expected);
        @(posedge clk_i);
        instr_valid_i <= valid;
        instr_i       <= instr;
        pc_i          <= pc;
        exp_q.push_back(expected);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count <= cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_i         = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        pc_i          = '0;
        load_stimulus();
        if (n_lines == 0) begin
            $display("no stimulus lines could be read, nothing was tested");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            cycle_limit = n_lines + 20;
            repeat (RESET_CYCLES) @(posedge clk_i);
            rst_i <= 1'b0;
            for (int i = 0; i < n_lines; i++) begin
                drive_slot(stim_valid[i], stim_instr[i], stim_pc[i], stim_exp[i]);
            end
            repeat (DRAIN_CYCLES) drive_slot(1'b0, '0, '0, '0);
            @(posedge clk_i);
            u_checker.print_summary();
            if (u_checker.error_count == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule
